// File: flist.f
+incdir+verilog
verilog/cpu_types_pkg.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/register_file.sv
verilog/hazard_unit.sv
verilog/datapath.sv
verif/clock_gen.sv
verif/tb_datapath.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_datapath
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/datapath_tests.mem
// header: [23:16] program words, [15:8] data words, [7:0] expected stores
// then program words, initial data words, expected stores as address data pairs
0028020F
8C010000 // lw   $1, 0($0)
8C020004 // lw   $2, 4($0)
00221821 // addu $3, $1, $2    load use stall
AC030080 // sw   $3, 0x80($0)
00222023 // subu $4, $1, $2
00222824 // and  $5, $1, $2
AC040084 // sw   $4, 0x84($0)  distance two
00853025 // or   $6, $4, $5
00C13826 // xor  $7, $6, $1    distance one
0041402A // slt  $8, $2, $1    negative operand
0022482A // slt  $9, $1, $2
AC050088 // sw   $5, 0x88($0)
AC06008C // sw   $6, 0x8C($0)
AC070090 // sw   $7, 0x90($0)
AC080094 // sw   $8, 0x94($0)
AC090098 // sw   $9, 0x98($0)
242AFFFC // addiu $10, $1, -4
304BFF0F // andi $11, $2, 0xFF0F
340C8001 // ori  $12, $0, 0x8001
3C0DABCD // lui  $13, 0xABCD
AC0A009C // sw   $10, 0x9C($0)
AC0B00A0 // sw   $11, 0xA0($0)
AC0C00A4 // sw   $12, 0xA4($0)
AC0D00A8 // sw   $13, 0xA8($0)
24200005 // addiu $0, $1, 5    r0 stays zero
AC0000AC // sw   $0, 0xAC($0)
00017021 // addu $14, $0, $1
AC0E00B0 // sw   $14, 0xB0($0)
10210002 // beq  $1, $1, +2    taken
AC0100F0 // sw   $1, 0xF0($0)  skipped
AC0100F4 // sw   $1, 0xF4($0)  skipped
14210001 // bne  $1, $1, +1    not taken
AC0300B4 // sw   $3, 0xB4($0)
08000024 // j    0x90
AC0100F8 // sw   $1, 0xF8($0)  skipped
AC0100FC // sw   $1, 0xFC($0)  skipped
AC0C00B8 // sw   $12, 0xB8($0)
FC000000 // halt
AC0100EC // sw   $1, 0xEC($0)  never reached
AC0100E8 // sw   $1, 0xE8($0)  never reached
// data words 0 and 1
00001234
FFFFFFF0
// expected stores
00000080 00001224
00000084 00001244
00000088 00001230
0000008C 00001274
00000090 00000040
00000094 00000001
00000098 00000000
0000009C 00001230
000000A0 0000FF00
000000A4 00008001
000000A8 ABCD0000
000000AC 00000000
000000B0 00001234
000000B4 00001224
000000B8 00008001

// File: verif/tb_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_datapath;

  localparam int    MEM_WORDS    = 256;
  localparam int    DRAIN_CYCLES = 8;
  localparam string TESTS_FILE   = "verif/datapath_tests.mem";

  logic                 CLK;
  logic                 reset;
  cpu_types_pkg::word_t imem_addr;
  cpu_types_pkg::word_t imem_data;
  cpu_types_pkg::word_t dmem_addr;
  cpu_types_pkg::word_t dmem_store;
  cpu_types_pkg::word_t dmem_load;
  logic                 dmem_ren;
  logic                 dmem_wen;
  logic                 halt;

  cpu_types_pkg::word_t tests [MEM_WORDS];
  cpu_types_pkg::word_t rom [MEM_WORDS];
  cpu_types_pkg::word_t ram [MEM_WORDS];

  int   prog_len;
  int   data_len;
  int   store_len;
  int   stores_base;
  int   store_idx;
  int   cycle_count;
  int   cycle_limit;
  int   drain;
  int   value_errors;
  int   other_errors;
  logic halt_seen;

  clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clock (
    .CLK   (CLK),
    .reset (reset)
  );

  datapath dut (
    .CLK        (CLK),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_load  (dmem_load),
    .halt       (halt)
  );

  // both memories answer in the same cycle
  assign imem_data = rom[imem_addr[9:2]];
  // load data only while a read is requested
  assign dmem_load = dmem_ren ? ram[dmem_addr[9:2]] : '0;

  always @(posedge CLK) begin
    if (dmem_wen) begin
      ram[dmem_addr[9:2]] <= dmem_store;
    end
  end

  // header packs program, data and store counts into one word
  task automatic load_tests();
    cpu_types_pkg::word_t header;
    $readmemh(TESTS_FILE, tests);
    header      = tests[0];
    prog_len    = int'(header[23:16]);
    data_len    = int'(header[15:8]);
    store_len   = int'(header[7:0]);
    stores_base = 1 + prog_len + data_len;
    for (int i = 0; i < MEM_WORDS; i++) begin
      // fetches past the program hit a halt
      rom[i] = 32'hfc00_0000 | 32'(i);
      ram[i] = 32'hbad0_0000 | 32'(i);
    end
    for (int i = 0; i < prog_len; i++) begin
      rom[i] = tests[1 + i];
    end
    for (int i = 0; i < data_len; i++) begin
      ram[i] = tests[1 + prog_len + i];
    end
  endtask

  function automatic cpu_types_pkg::word_t expected_addr(input int k);
    return tests[stores_base + 2 * k];
  endfunction

  function automatic cpu_types_pkg::word_t expected_data(input int k);
    return tests[stores_base + 2 * k + 1];
  endfunction

  task automatic check_reset_state();
    if (dmem_wen || dmem_ren || halt) begin
      $display("memory strobes or halt not low after reset at %0t", $time);
      other_errors++;
    end
  endtask

  task automatic check_store();
    if (dmem_wen) begin
      if (dmem_ren) begin
        $display("dmem_ren high during a store at %0t", $time);
        other_errors++;
      end
      if (halt) begin
        $display("store to %h after halt at %0t", dmem_addr, $time);
        other_errors++;
      end else if (store_idx >= store_len) begin
        $display("unexpected extra store to %h at %0t", dmem_addr, $time);
        other_errors++;
      end else begin
        if (dmem_addr !== expected_addr(store_idx)) begin
          $display("FAILED at %0t: dmem_addr expected %h, got %h",
                   $time, expected_addr(store_idx), dmem_addr);
          value_errors++;
        end
        if (dmem_store !== expected_data(store_idx)) begin
          $display("FAILED at %0t: dmem_store expected %h, got %h",
                   $time, expected_data(store_idx), dmem_store);
          value_errors++;
        end
        store_idx++;
      end
    end
  endtask

  initial begin
    value_errors = 0;
    other_errors = 0;
    store_idx    = 0;
    cycle_count  = 0;
    drain        = 0;
    halt_seen    = 1'b0;
    load_tests();
    cycle_limit = 8 * prog_len + 64;

    // outputs sampled mid-cycle
    @(negedge CLK);
    while (reset) begin
      @(negedge CLK);
    end
    check_reset_state();

    // keep watching a few cycles past halt for stray stores
    while (drain < DRAIN_CYCLES && cycle_count < cycle_limit) begin
      @(negedge CLK);
      cycle_count++;
      check_store();
      if (halt) begin
        if (!halt_seen) begin
          halt_seen = 1'b1;
          if (store_idx != store_len) begin
            $display("halt reached after %0d of %0d expected stores", store_idx, store_len);
            other_errors++;
          end
        end
        drain++;
      end else if (halt_seen) begin
        $display("halt output dropped at %0t", $time);
        other_errors++;
        drain++;
      end
    end

    if (!halt_seen) begin
      $display("timeout, halt not reached within %0d cycles", cycle_limit);
      other_errors++;
    end

    $display("errors: %0d value mismatches, %0d other failures, %0d of %0d stores seen",
             value_errors, other_errors, store_idx, store_len);
    if (value_errors + other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic reset
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // reset released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: verilog/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = `PC_INIT_DEFAULT
) (
  input  logic                 CLK,
  input  logic                 reset,
  output cpu_types_pkg::word_t imem_addr,
  input  cpu_types_pkg::word_t imem_data,
  output cpu_types_pkg::word_t dmem_addr,
  output cpu_types_pkg::word_t dmem_store,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  input  cpu_types_pkg::word_t dmem_load,
  output logic                 halt
);

  cpu_types_pkg::word_t    pc, pc_plus4, ex_target;
  cpu_types_pkg::if_id_t   if_id;
  cpu_types_pkg::id_ex_t   id_ex, id_ex_in;
  cpu_types_pkg::ex_mem_t  ex_mem;
  cpu_types_pkg::mem_wb_t  mem_wb;
  cpu_types_pkg::ctrl_t    dec_ctrl;
  cpu_types_pkg::word_t    rf_rdat1, rf_rdat2, wb_data;
  cpu_types_pkg::word_t    op_a, rt_val, op_b, alu_result, branch_target;
  cpu_types_pkg::fwd_sel_t fwd_a, fwd_b;
  cpu_types_pkg::regbits_t dec_rs, dec_rt, dec_rd, wb_dst;
  logic                    alu_zero, ex_taken, stall, flush;
  logic                    halt_q, halt_pending, hold;

  function automatic cpu_types_pkg::word_t fwd_mux(input cpu_types_pkg::fwd_sel_t sel,
                                                   input cpu_types_pkg::word_t reg_val);
    case (sel)
      cpu_types_pkg::FWD_MEM: return ex_mem.result;
      cpu_types_pkg::FWD_WB:  return wb_data;
      default:                return reg_val;
    endcase
  endfunction

  // fetch
  assign imem_addr = pc;
  assign pc_plus4  = pc + 32'd4;

  // no fetch progress while halting or on a load-use stall
  assign halt_pending = halt | id_ex.ctrl.halt | ex_mem.ctrl.halt;
  assign hold         = stall | halt_pending;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc           <= PC_INIT;
      if_id.valid  <= 1'b0;
    end else if (flush) begin
      pc           <= ex_target;
      if_id.valid  <= 1'b0;
    end else if (!hold) begin
      pc           <= pc_plus4;
      if_id        <= '{valid: 1'b1, pc_plus4: pc_plus4, instr: imem_data};
    end
  end

  // decode
  assign dec_rs = if_id.instr[25:21];
  assign dec_rt = if_id.instr[20:16];
  assign dec_rd = if_id.instr[15:11];

  control_unit u_control (
    .instr (if_id.instr),
    .valid (if_id.valid),
    .ctrl  (dec_ctrl)
  );

  register_file u_regs (
    .CLK   (CLK),
    .reset (reset),
    .wen   (mem_wb.ctrl.reg_wen),
    .wsel  (wb_dst),
    .wdat  (wb_data),
    .rsel1 (dec_rs),
    .rsel2 (dec_rt),
    .rdat1 (rf_rdat1),
    .rdat2 (rf_rdat2)
  );

  always_comb begin
    id_ex_in.ctrl        = (flush || hold) ? '0 : dec_ctrl;
    id_ex_in.pc_plus4    = if_id.pc_plus4;
    id_ex_in.rdat1       = rf_rdat1;
    id_ex_in.rdat2       = rf_rdat2;
    // lui is zero extended here and shifted in the alu
    id_ex_in.imm_ext     = dec_ctrl.sign_ext ? {{16{if_id.instr[15]}}, if_id.instr[15:0]}
                                             : {16'h0000, if_id.instr[15:0]};
    id_ex_in.rs          = dec_rs;
    id_ex_in.rt          = dec_rt;
    id_ex_in.dst         = dec_ctrl.dst_is_rt ? dec_rt : dec_rd;
    id_ex_in.jump_target = {if_id.pc_plus4[31:28], if_id.instr[25:0], 2'b00};
  end

  always_ff @(posedge CLK) begin
    if (reset) id_ex.ctrl <= '0;
    else id_ex <= id_ex_in;
  end

  // execute
  hazard_unit u_hazard (
    .id_rs       (dec_rs),
    .id_rt       (dec_rt),
    .ex_rs       (id_ex.rs),
    .ex_rt       (id_ex.rt),
    .ex_mem_read (id_ex.ctrl.mem_read),
    .ex_dst      (id_ex.dst),
    .mem_wen     (ex_mem.ctrl.reg_wen),
    .mem_dst     (ex_mem.dst),
    .wb_wen      (mem_wb.ctrl.reg_wen),
    .wb_dst      (wb_dst),
    .ex_taken    (ex_taken),
    .stall       (stall),
    .flush       (flush),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b)
  );

  always_comb begin
    op_a   = fwd_mux(fwd_a, id_ex.rdat1);
    // forwarded rt also supplies the store data
    rt_val = fwd_mux(fwd_b, id_ex.rdat2);
  end

  assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : rt_val;

  alu u_alu (
    .a      (op_a),
    .b      (op_b),
    .op     (id_ex.ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  assign branch_target = id_ex.pc_plus4 + {id_ex.imm_ext[29:0], 2'b00};
  assign ex_taken      = (id_ex.ctrl.branch_eq && alu_zero) ||
                         (id_ex.ctrl.branch_ne && !alu_zero) || id_ex.ctrl.jump;
  assign ex_target     = id_ex.ctrl.jump ? id_ex.jump_target : branch_target;

  always_ff @(posedge CLK) begin
    if (reset) begin
      ex_mem.ctrl       <= '0;
    end else begin
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.result     <= alu_result;
      ex_mem.store_data <= rt_val;
      ex_mem.dst        <= id_ex.dst;
    end
  end

  // memory
  assign dmem_addr  = ex_mem.result;
  assign dmem_store = ex_mem.store_data;
  assign dmem_ren   = ex_mem.ctrl.mem_read;
  assign dmem_wen   = ex_mem.ctrl.mem_write;

  always_ff @(posedge CLK) begin
    if (reset) begin
      mem_wb.ctrl      <= '0;
    end else begin
      mem_wb.ctrl      <= ex_mem.ctrl;
      mem_wb.result    <= ex_mem.result;
      mem_wb.load_data <= dmem_load;
      mem_wb.dst       <= ex_mem.dst;
    end
  end

  // writeback
  assign wb_dst  = mem_wb.dst;
  assign wb_data = mem_wb.ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.result;

  // halt sticks once the halt instruction reaches writeback
  always_ff @(posedge CLK) begin
    if (reset) halt_q <= 1'b0;
    else if (mem_wb.ctrl.halt) halt_q <= 1'b1;
  end

  assign halt = halt_q | mem_wb.ctrl.halt;

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_types_pkg::regbits_t  id_rs,
  input  cpu_types_pkg::regbits_t  id_rt,
  input  cpu_types_pkg::regbits_t  ex_rs,
  input  cpu_types_pkg::regbits_t  ex_rt,
  input  logic                     ex_mem_read,
  input  cpu_types_pkg::regbits_t  ex_dst,
  input  logic                     mem_wen,
  input  cpu_types_pkg::regbits_t  mem_dst,
  input  logic                     wb_wen,
  input  cpu_types_pkg::regbits_t  wb_dst,
  input  logic                     ex_taken,
  output logic                     stall,
  output logic                     flush,
  output cpu_types_pkg::fwd_sel_t  fwd_a,
  output cpu_types_pkg::fwd_sel_t  fwd_b
);

  logic load_use;

  // newest producer wins, r0 never forwarded
  function automatic cpu_types_pkg::fwd_sel_t pick_src(input cpu_types_pkg::regbits_t src);
    cpu_types_pkg::fwd_sel_t sel;
    sel = cpu_types_pkg::FWD_NONE;
    if (mem_wen && (mem_dst != '0) && (mem_dst == src)) begin
      sel = cpu_types_pkg::FWD_MEM;
    end else if (wb_wen && (wb_dst != '0) && (wb_dst == src)) begin
      sel = cpu_types_pkg::FWD_WB;
    end
    return sel;
  endfunction

  // load in execute feeding the instruction in decode
  assign load_use = ex_mem_read && (ex_dst != '0) &&
                    ((ex_dst == id_rs) || (ex_dst == id_rt));

  // a redirect discards the stalled instruction anyway
  assign flush = ex_taken;
  assign stall = load_use && !ex_taken;

  always_comb begin
    fwd_a = pick_src(ex_rs);
    fwd_b = pick_src(ex_rt);
  end

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module register_file (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [`NUM_REGS];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  // r0 reads zero, same-cycle write is passed straight through
  always_comb begin
    if (rsel1 == '0) rdat1 = '0;
    else if (wen && (wsel == rsel1)) rdat1 = wdat;
    else rdat1 = regs[rsel1];

    if (rsel2 == '0) rdat2 = '0;
    else if (wen && (wsel == rsel2)) rdat2 = wdat;
    else rdat2 = regs[rsel2];
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_types_pkg::word_t   a,
  input  cpu_types_pkg::word_t   b,
  input  cpu_types_pkg::alu_op_t op,
  output cpu_types_pkg::word_t   result,
  output logic                   zero
);

  always_comb begin
    case (op)
      cpu_types_pkg::ALU_ADD: result = a + b;
      cpu_types_pkg::ALU_SUB: result = a - b;
      cpu_types_pkg::ALU_AND: result = a & b;
      cpu_types_pkg::ALU_OR:  result = a | b;
      cpu_types_pkg::ALU_XOR: result = a ^ b;
      // signed compare, result is 0 or 1
      cpu_types_pkg::ALU_SLT: result = cpu_types_pkg::word_t'($signed(a) < $signed(b));
      // immediate goes to the upper half
      cpu_types_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
      default:                result = '0;
    endcase
  end

  // used by beq and bne
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  cpu_types_pkg::word_t instr,
  input  logic                 valid,
  output cpu_types_pkg::ctrl_t ctrl
);

  cpu_types_pkg::opcode_t opcode;
  cpu_types_pkg::funct_t  funct;

  assign opcode = cpu_types_pkg::opcode_t'(instr[31:26]);
  assign funct  = cpu_types_pkg::funct_t'(instr[5:0]);

  always_comb begin
    ctrl = '0;
    if (valid) begin
      case (opcode)
        cpu_types_pkg::RTYPE: begin
          ctrl.reg_wen = 1'b1;
          case (funct)
            cpu_types_pkg::ADDU: ctrl.alu_op = cpu_types_pkg::ALU_ADD;
            cpu_types_pkg::SUBU: ctrl.alu_op = cpu_types_pkg::ALU_SUB;
            cpu_types_pkg::AND:  ctrl.alu_op = cpu_types_pkg::ALU_AND;
            cpu_types_pkg::OR:   ctrl.alu_op = cpu_types_pkg::ALU_OR;
            cpu_types_pkg::XOR:  ctrl.alu_op = cpu_types_pkg::ALU_XOR;
            cpu_types_pkg::SLT:  ctrl.alu_op = cpu_types_pkg::ALU_SLT;
            // unsupported funct behaves as a bubble
            default:             ctrl.reg_wen = 1'b0;
          endcase
        end
        cpu_types_pkg::ADDIU: begin
          ctrl.reg_wen     = 1'b1;
          ctrl.dst_is_rt   = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.sign_ext    = 1'b1;
        end
        cpu_types_pkg::ANDI: begin
          ctrl.reg_wen     = 1'b1;
          ctrl.dst_is_rt   = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.alu_op      = cpu_types_pkg::ALU_AND;
        end
        cpu_types_pkg::ORI: begin
          ctrl.reg_wen     = 1'b1;
          ctrl.dst_is_rt   = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.alu_op      = cpu_types_pkg::ALU_OR;
        end
        cpu_types_pkg::LUI: begin
          ctrl.reg_wen     = 1'b1;
          ctrl.dst_is_rt   = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.alu_op      = cpu_types_pkg::ALU_LUI;
        end
        cpu_types_pkg::LW: begin
          ctrl.reg_wen     = 1'b1;
          ctrl.dst_is_rt   = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.sign_ext    = 1'b1;
          ctrl.mem_read    = 1'b1;
          ctrl.mem_to_reg  = 1'b1;
        end
        cpu_types_pkg::SW: begin
          ctrl.alu_src_imm = 1'b1;
          ctrl.sign_ext    = 1'b1;
          ctrl.mem_write   = 1'b1;
        end
        // branches compare rs and rt by subtraction
        cpu_types_pkg::BEQ: begin
          ctrl.sign_ext  = 1'b1;
          ctrl.branch_eq = 1'b1;
          ctrl.alu_op    = cpu_types_pkg::ALU_SUB;
        end
        cpu_types_pkg::BNE: begin
          ctrl.sign_ext  = 1'b1;
          ctrl.branch_ne = 1'b1;
          ctrl.alu_op    = cpu_types_pkg::ALU_SUB;
        end
        cpu_types_pkg::J:    ctrl.jump = 1'b1;
        cpu_types_pkg::HALT: ctrl.halt = 1'b1;
        default:             ctrl = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/cpu_types_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`REG_SEL_W-1:0] regbits_t;

  // primary opcodes, MIPS encoding
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ANDI  = 6'h0C,
    ORI   = 6'h0D,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    HALT  = `HALT_OPCODE
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2A
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_LUI
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  // all zero means bubble
  typedef struct packed {
    logic    reg_wen;
    logic    dst_is_rt;
    logic    alu_src_imm;
    logic    sign_ext;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    branch_eq;
    logic    branch_ne;
    logic    jump;
    logic    halt;
    alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc_plus4;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    pc_plus4;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm_ext;
    regbits_t rs;
    regbits_t rt;
    regbits_t dst;
    word_t    jump_target;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    result;
    word_t    store_data;
    regbits_t dst;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    result;
    word_t    load_data;
    regbits_t dst;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: verilog/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define WORD_W 32

// register index width
`define REG_SEL_W 5

// architectural register count
`define NUM_REGS 32

// fetch address after reset
`define PC_INIT_DEFAULT 32'h0000_0000

// opcode that stops the pipeline
`define HALT_OPCODE 6'h3F

`endif
